/* common/isa_pkg.sv */
package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_index_t;
	typedef logic [15:0] pc_t;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_ADDIU   = 6'h09,
		OP_HALT    = 6'h3d,
		OP_SEND    = 6'h3e,
		OP_RECV    = 6'h3f
	} opcode_t;

	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_OR   = 6'h25
	} funct_t;

	// fetch to execute, pc zero extended
	typedef struct packed {
		logic valid;
		pc_t pc;
		word_t inst;
	} fetch_bundle_t;

	typedef struct packed {
		opcode_t op;
		reg_index_t rs;
		reg_index_t rt;
		reg_index_t rd;
		logic [4:0] shamt;
		funct_t fn;
		logic [15:0] imm;
	} decoded_t;

endpackage

/* common/serial_pkg.sv */
package serial_pkg;

	typedef logic [7:0] byte_t;

	// valid held until the consumer takes the word
	typedef struct packed {
		logic valid;
		isa_pkg::word_t data;
	} word_stream_t;

endpackage

/* uart/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 868
) (
	input logic CLK,
	input logic reset,
	input logic rx,
	output serial_pkg::byte_t rx_byte,
	output logic byte_valid
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam logic [CW-1:0] HALF_BIT = CW'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);

	rx_state_t state;
	logic [1:0] rx_sync;
	logic [CW-1:0] clk_cnt;
	logic [2:0] bit_idx;

	// two flops, line idles high
	always_ff @(posedge CLK) begin
		if (reset) begin
			rx_sync <= 2'b11;
		end else begin
			rx_sync <= {rx_sync[0], rx};
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync[1]) state <= RX_START;
				end
				RX_START: begin
					if (clk_cnt == HALF_BIT) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// line back high at mid-bit, not a real start
						state <= rx_sync[1] ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (clk_cnt == FULL_BIT) begin
						clk_cnt <= '0;
						rx_byte <= {rx_sync[1], rx_byte[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (clk_cnt == FULL_BIT) begin
						// framing error drops the byte
						byte_valid <= rx_sync[1];
						state <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	a_single_pulse: assert property (@(posedge CLK) disable iff (reset)
		byte_valid |=> !byte_valid);

endmodule

/* uart/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 868
) (
	input logic CLK,
	input logic reset,
	input logic tx_start,
	input serial_pkg::byte_t tx_byte,
	output logic tx,
	output logic tx_ready
);

	typedef enum logic {TX_IDLE, TX_SEND} tx_state_t;

	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);

	tx_state_t state;
	logic [CW-1:0] clk_cnt;
	logic [3:0] bit_idx;
	logic [8:0] frame;

	assign tx_ready = (state == TX_IDLE);

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= TX_IDLE;
			tx <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (tx_start) begin
						// data lsb first, stop bit shifts in behind
						frame <= {1'b1, tx_byte};
						tx <= 1'b0;
						clk_cnt <= '0;
						bit_idx <= '0;
						state <= TX_SEND;
					end
				end
				TX_SEND: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (clk_cnt == FULL_BIT) begin
						clk_cnt <= '0;
						if (bit_idx == 4'd9) begin
							state <= TX_IDLE;
						end else begin
							tx <= frame[0];
							frame <= {1'b1, frame[8:1]};
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	a_start_when_ready: assert property (@(posedge CLK) disable iff (reset)
		tx_start |-> tx_ready);

endmodule

/* rtl/word_assembler.sv */
`timescale 1ns/1ps

module word_assembler (
	input logic CLK,
	input logic reset,
	input serial_pkg::byte_t rx_byte,
	input logic byte_valid,
	output serial_pkg::word_stream_t word_out,
	input logic word_ready
);

	logic [23:0] partial;
	logic [31:0] word_data;
	logic [1:0] byte_cnt;
	logic word_valid;
	logic take_byte;

	// byte lost if the previous word is still waiting
	assign take_byte = byte_valid && (!word_valid || word_ready);
	assign word_out = {word_valid, word_data};

	always_ff @(posedge CLK) begin
		if (reset) begin
			byte_cnt <= '0;
			word_valid <= 1'b0;
		end else begin
			if (word_valid && word_ready) word_valid <= 1'b0;
			if (take_byte) begin
				byte_cnt <= byte_cnt + 1'b1;
				if (byte_cnt == 2'd3) word_valid <= 1'b1;
			end
		end
	end

	// first byte ends up in the top
	always_ff @(posedge CLK) begin
		if (take_byte) begin
			partial <= {partial[15:0], rx_byte};
			if (byte_cnt == 2'd3) word_data <= {partial, rx_byte};
		end
	end

endmodule

/* rtl/word_sender.sv */
`timescale 1ns/1ps

module word_sender (
	input logic CLK,
	input logic reset,
	input serial_pkg::word_stream_t send_req,
	output logic send_ready,
	output logic tx_start,
	output serial_pkg::byte_t tx_byte,
	input logic tx_ready
);

	import isa_pkg::*;

	typedef enum logic [1:0] {WS_IDLE, WS_START, WS_WAIT} ws_state_t;

	ws_state_t state;
	word_t hold;
	logic [1:0] byte_idx;

	assign send_ready = (state == WS_IDLE);
	assign tx_start = (state == WS_START);
	assign tx_byte = hold[31:24];

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= WS_IDLE;
			byte_idx <= '0;
		end else begin
			case (state)
				WS_IDLE: begin
					if (send_req.valid) begin
						byte_idx <= '0;
						state <= WS_START;
					end
				end
				WS_START: state <= WS_WAIT;
				WS_WAIT: begin
					// tx_ready is already low the cycle after tx_start
					if (tx_ready) begin
						if (byte_idx == 2'd3) begin
							state <= WS_IDLE;
						end else begin
							byte_idx <= byte_idx + 1'b1;
							state <= WS_START;
						end
					end
				end
				default: state <= WS_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (send_ready && send_req.valid) begin
			hold <= send_req.data;
		end else if (state == WS_WAIT && tx_ready) begin
			hold <= {hold[23:0], 8'h00};
		end
	end

endmodule

/* core/inst_fetch.sv */
`timescale 1ns/1ps

module inst_fetch #(
	parameter int INST_MEM_WIDTH = 8
) (
	input logic CLK,
	input logic reset,
	input logic load_start,
	input logic load_end,
	input serial_pkg::word_stream_t load_word,
	output logic load_ready,
	input logic stall,
	input logic halted,
	output isa_pkg::fetch_bundle_t fetch_out,
	output logic running
);

	import isa_pkg::*;

	localparam int DEPTH = 2 ** INST_MEM_WIDTH;

	word_t imem [DEPTH];
	logic [INST_MEM_WIDTH-1:0] load_addr;
	logic [INST_MEM_WIDTH-1:0] pc;
	logic load_fire;
	logic advance;
	logic fetch_valid;
	pc_t fetch_pc;
	word_t fetch_inst;

	// no word taken on the mode switch cycles
	assign load_ready = !running && !load_start && !load_end;
	assign load_fire = load_ready && load_word.valid;
	assign advance = running && !stall && !halted && !load_start && !load_end;
	assign fetch_out = {fetch_valid, fetch_pc, fetch_inst};

	always_ff @(posedge CLK) begin
		if (reset) begin
			running <= 1'b0;
			load_addr <= '0;
			pc <= '0;
			fetch_valid <= 1'b0;
		end else if (load_start) begin
			running <= 1'b0;
			load_addr <= '0;
			fetch_valid <= 1'b0;
		end else if (load_end) begin
			running <= 1'b1;
			pc <= '0;
			fetch_valid <= 1'b0;
		end else if (load_fire) begin
			load_addr <= load_addr + 1'b1;
		end else if (running && !stall) begin
			fetch_valid <= !halted;
			if (advance) pc <= pc + 1'b1;
		end
	end

	// synchronous read straight into the fetch register
	always_ff @(posedge CLK) begin
		if (load_fire) imem[load_addr] <= load_word.data;
		if (advance) begin
			fetch_inst <= imem[pc];
			fetch_pc <= pc_t'(pc);
		end
	end

endmodule

/* core/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
	input logic CLK,
	input logic reset,
	input isa_pkg::fetch_bundle_t fetch_in,
	output logic stall,
	output logic halted,
	input serial_pkg::word_stream_t recv_word,
	output logic recv_ready,
	output serial_pkg::word_stream_t send_req,
	input logic send_ready
);

	import isa_pkg::*;

	word_t regs [32];
	decoded_t dec;
	word_t rs_val;
	word_t rt_val;
	word_t result;
	reg_index_t wr_idx;
	logic wr_en;
	logic exec_en;
	logic is_send;
	logic is_recv;

	always_comb begin
		dec.op = opcode_t'(fetch_in.inst[31:26]);
		dec.rs = fetch_in.inst[25:21];
		dec.rt = fetch_in.inst[20:16];
		dec.rd = fetch_in.inst[15:11];
		dec.shamt = fetch_in.inst[10:6];
		dec.fn = funct_t'(fetch_in.inst[5:0]);
		dec.imm = fetch_in.inst[15:0];
	end

	// nothing runs after halt
	assign exec_en = fetch_in.valid && !halted;
	assign is_send = exec_en && (dec.op == OP_SEND);
	assign is_recv = exec_en && (dec.op == OP_RECV);

	assign rs_val = (dec.rs == '0) ? '0 : regs[dec.rs];
	assign rt_val = (dec.rt == '0) ? '0 : regs[dec.rt];

	assign stall = (is_send && !send_ready) || (is_recv && !recv_word.valid);
	assign recv_ready = is_recv;
	assign send_req = {is_send, rs_val};

	always_comb begin
		result = '0;
		wr_en = 1'b0;
		wr_idx = dec.rt;
		case (dec.op)
			OP_SPECIAL: begin
				wr_idx = dec.rd;
				wr_en = 1'b1;
				case (dec.fn)
					FN_ADDU: result = rs_val + rt_val;
					FN_SUBU: result = rs_val - rt_val;
					FN_OR: result = rs_val | rt_val;
					FN_SLL: result = rt_val << dec.shamt;
					default: wr_en = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				result = rs_val + {{16{dec.imm[15]}}, dec.imm};
				wr_en = 1'b1;
			end
			OP_RECV: begin
				// written only in the cycle the word is taken
				result = recv_word.data;
				wr_en = recv_word.valid;
			end
			default: wr_en = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (exec_en && wr_en) regs[wr_idx] <= result;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			halted <= 1'b0;
		end else if (exec_en && dec.op == OP_HALT) begin
			halted <= 1'b1;
		end
	end

	// fetch must hold its register while this stage waits
	a_fetch_hold: assert property (@(posedge CLK) disable iff (reset)
		stall |=> $stable(fetch_in));

	a_send_stable: assert property (@(posedge CLK) disable iff (reset)
		send_req.valid && !send_ready |=> $stable(send_req));

endmodule

/* rtl/uart_cpu_top.sv */
`timescale 1ns/1ps

module uart_cpu_top #(
	parameter int INST_MEM_WIDTH = 8,
	parameter int CLKS_PER_BIT = 868
) (
	input logic CLK,
	input logic reset,
	input logic UART_RX,
	input logic load_start,
	input logic load_end,
	output logic UART_TX,
	output logic [7:0] led
);

	import isa_pkg::*;
	import serial_pkg::*;

	byte_t rx_byte;
	byte_t tx_byte;
	logic byte_valid;
	logic tx_start;
	logic tx_ready;
	word_stream_t rx_word;
	word_stream_t load_word;
	word_stream_t recv_word;
	word_stream_t send_req;
	logic rx_word_ready;
	logic load_ready;
	logic recv_ready;
	logic send_ready;
	fetch_bundle_t fetch;
	logic stall;
	logic halted;
	logic running;
	logic core_reset;

	// a new program load also clears a halted core
	assign core_reset = reset || load_start;

	// received words feed program memory or the core
	assign load_word = {rx_word.valid && !running, rx_word.data};
	assign recv_word = {rx_word.valid && running, rx_word.data};
	assign rx_word_ready = running ? recv_ready : load_ready;

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
		.CLK(CLK), .reset(reset), .rx(UART_RX),
		.rx_byte(rx_byte), .byte_valid(byte_valid)
	);

	word_assembler u_word_assembler (
		.CLK(CLK), .reset(reset), .rx_byte(rx_byte), .byte_valid(byte_valid),
		.word_out(rx_word), .word_ready(rx_word_ready)
	);

	inst_fetch #(.INST_MEM_WIDTH(INST_MEM_WIDTH)) u_inst_fetch (
		.CLK(CLK), .reset(reset), .load_start(load_start), .load_end(load_end),
		.load_word(load_word), .load_ready(load_ready), .stall(stall),
		.halted(halted), .fetch_out(fetch), .running(running)
	);

	execute_stage u_execute_stage (
		.CLK(CLK), .reset(core_reset), .fetch_in(fetch), .stall(stall),
		.halted(halted), .recv_word(recv_word), .recv_ready(recv_ready),
		.send_req(send_req), .send_ready(send_ready)
	);

	word_sender u_word_sender (
		.CLK(CLK), .reset(reset), .send_req(send_req), .send_ready(send_ready),
		.tx_start(tx_start), .tx_byte(tx_byte), .tx_ready(tx_ready)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
		.CLK(CLK), .reset(reset), .tx_start(tx_start), .tx_byte(tx_byte),
		.tx(UART_TX), .tx_ready(tx_ready)
	);

	// top byte of every accepted send word
	always_ff @(posedge CLK) begin
		if (reset) begin
			led <= 8'b01010101;
		end else if (send_req.valid && send_ready) begin
			led <= send_req.data[31:24];
		end
	end

endmodule

/* tb/uart_cpu_tb.sv */
`timescale 1ns/1ps

module uart_cpu_tb;

	import isa_pkg::*;

	localparam int CPB = 8;
	localparam int PROG_WORDS = 18;
	localparam int SEND_WORDS = 7;
	localparam int SENDS_BEFORE_RECV = 3;
	// every byte at 10 bit times, then the halt window and some slack
	localparam int TIMEOUT_CYCLES = ((PROG_WORDS + 1 + SEND_WORDS) * 40 + 60) * CPB + 2000;

	logic CLK = 1'b0;
	logic reset;
	logic UART_RX;
	logic load_start;
	logic load_end;
	logic UART_TX;
	logic [7:0] led;

	logic quiet_phase;
	logic halt_window;
	integer seed;
	word_t rand_word;
	word_t prog [$];
	word_t expected [$];
	int errors = 0;
	int words_seen = 0;
	int bytes_seen = 0;
	int cycles = 0;

	uart_cpu_top #(.INST_MEM_WIDTH(6), .CLKS_PER_BIT(CPB)) DUT (
		.CLK(CLK), .reset(reset), .UART_RX(UART_RX), .load_start(load_start),
		.load_end(load_end), .UART_TX(UART_TX), .led(led)
	);

	always #2 CLK = ~CLK;

	function automatic word_t alu_inst(funct_t fn, reg_index_t rd, reg_index_t rs,
			reg_index_t rt, logic [4:0] shamt);
		return {OP_SPECIAL, rs, rt, rd, shamt, fn};
	endfunction

	function automatic word_t addiu_inst(reg_index_t rt, reg_index_t rs, logic [15:0] imm);
		return {OP_ADDIU, rs, rt, imm};
	endfunction

	function automatic word_t send_inst(reg_index_t rs);
		return {OP_SEND, rs, 21'd0};
	endfunction

	function automatic word_t recv_inst(reg_index_t rt);
		return {OP_RECV, 5'd0, rt, 16'd0};
	endfunction

	task automatic build_program();
		prog.push_back(addiu_inst(5'd1, 5'd0, 16'h1234));
		prog.push_back(addiu_inst(5'd2, 5'd0, 16'hfffd));
		prog.push_back(alu_inst(FN_ADDU, 5'd3, 5'd1, 5'd2, 5'd0));
		prog.push_back(alu_inst(FN_SUBU, 5'd4, 5'd1, 5'd2, 5'd0));
		prog.push_back(alu_inst(FN_SLL, 5'd5, 5'd0, 5'd1, 5'd16));
		prog.push_back(alu_inst(FN_OR, 5'd6, 5'd5, 5'd4, 5'd0));
		prog.push_back(send_inst(5'd3));
		prog.push_back(send_inst(5'd6));
		prog.push_back(send_inst(5'd2));
		// blocks until the driver delivers the random word
		prog.push_back(recv_inst(5'd7));
		prog.push_back(addiu_inst(5'd8, 5'd7, 16'h0101));
		prog.push_back(send_inst(5'd8));
		// three sends in a row, sender back-pressure
		prog.push_back(send_inst(5'd4));
		prog.push_back(send_inst(5'd5));
		prog.push_back(send_inst(5'd1));
		prog.push_back({OP_HALT, 26'd0});
		// must never reach the line
		prog.push_back(send_inst(5'd6));
		prog.push_back(send_inst(5'd1));
	endtask

	// instruction-level model of the program, one entry per send
	task automatic predict_sends();
		word_t regs [32];
		word_t inst;
		word_t a;
		word_t b;
		int pc;
		logic done;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc = 0;
		done = 1'b0;
		while (!done && pc < prog.size()) begin
			inst = prog[pc];
			a = regs[inst[25:21]];
			b = regs[inst[20:16]];
			case (inst[31:26])
				OP_SPECIAL: begin
					case (inst[5:0])
						FN_ADDU: regs[inst[15:11]] = a + b;
						FN_SUBU: regs[inst[15:11]] = a - b;
						FN_OR: regs[inst[15:11]] = a | b;
						default: regs[inst[15:11]] = b << inst[10:6];
					endcase
				end
				OP_ADDIU: regs[inst[20:16]] = a + {{16{inst[15]}}, inst[15:0]};
				OP_RECV: regs[inst[20:16]] = rand_word;
				OP_SEND: expected.push_back(a);
				default: done = 1'b1;
			endcase
			regs[0] = '0;
			pc++;
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge CLK);
			#0.5;
		end
	endtask

	task automatic drive_byte(input serial_pkg::byte_t b);
		UART_RX = 1'b0;
		wait_cycles(CPB);
		for (int i = 0; i < 8; i++) begin
			UART_RX = b[i];
			wait_cycles(CPB);
		end
		UART_RX = 1'b1;
		wait_cycles(CPB);
	endtask

	task automatic drive_word(input word_t w);
		for (int i = 3; i >= 0; i--) begin
			drive_byte(w[8*i +: 8]);
		end
	endtask

	task automatic check_word(input word_t w);
		assert (words_seen < expected.size()) else begin
			errors++;
			$display("extra word %h showed up on UART_TX after the last expected send", w);
		end
		if (words_seen < expected.size()) begin
			assert (w == expected[words_seen]) else begin
				errors++;
				$display("CHECK FAILED send_word_%0d: expected %h, actual %h",
					words_seen, expected[words_seen], w);
			end
			assert (led == w[31:24]) else begin
				errors++;
				$display("CHECK FAILED led_%0d: expected %h, actual %h",
					words_seen, w[31:24], led);
			end
		end
		words_seen++;
	endtask

	// samples UART_TX at mid-bit
	initial begin : tx_monitor
		serial_pkg::byte_t rx;
		word_t w;
		w = '0;
		forever begin
			@(negedge UART_TX);
			repeat (CPB / 2) @(posedge CLK);
			for (int i = 0; i < 8; i++) begin
				repeat (CPB) @(posedge CLK);
				rx[i] = UART_TX;
			end
			repeat (CPB) @(posedge CLK);
			assert (UART_TX) else begin
				errors++;
				$display("stop bit on UART_TX was low, frame is broken");
			end
			w = {w[23:0], rx};
			bytes_seen++;
			if (bytes_seen % 4 == 0) begin
				check_word(w);
			end
		end
	end

	a_idle_after_reset: assert property (@(posedge CLK) disable iff (reset)
		quiet_phase |-> (UART_TX && led == 8'h55))
	else begin
		errors++;
		$display("CHECK FAILED after_reset: expected tx 1 led 55, actual tx %b led %h",
			$sampled(UART_TX), $sampled(led));
	end

	a_quiet_after_halt: assert property (@(posedge CLK) disable iff (reset)
		halt_window |-> UART_TX)
	else begin
		errors++;
		$display("UART_TX went low after halt, an instruction past the halt ran");
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles: errors=%0d words=%0d bytes=%0d",
				TIMEOUT_CYCLES, errors, words_seen, bytes_seen);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		seed = 32'h7a564df3;
		reset = 1'b1;
		UART_RX = 1'b1;
		load_start = 1'b0;
		load_end = 1'b0;
		quiet_phase = 1'b0;
		halt_window = 1'b0;
		rand_word = $random(seed);
		build_program();
		predict_sends();
		wait_cycles(8);
		reset = 1'b0;
		quiet_phase = 1'b1;
		wait_cycles(4 * CPB);
		load_start = 1'b1;
		wait_cycles(1);
		load_start = 1'b0;
		foreach (prog[i]) begin
			drive_word(prog[i]);
		end
		// let the last word reach the memory
		wait_cycles(2 * CPB);
		quiet_phase = 1'b0;
		load_end = 1'b1;
		wait_cycles(1);
		load_end = 1'b0;
		// core sits on the receive by now
		wait (words_seen == SENDS_BEFORE_RECV);
		wait_cycles(1);
		drive_word(rand_word);
		wait (words_seen == expected.size());
		wait_cycles(1);
		halt_window = 1'b1;
		wait_cycles(60 * CPB);
		halt_window = 1'b0;
		assert (bytes_seen == 4 * expected.size()) else begin
			errors++;
			$display("CHECK FAILED byte_count: expected %0d, actual %0d",
				4 * expected.size(), bytes_seen);
		end
		$display("errors=%0d words=%0d of %0d bytes=%0d",
			errors, words_seen, expected.size(), bytes_seen);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* uart_cpu_top.f */
common/isa_pkg.sv
common/serial_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
rtl/word_assembler.sv
rtl/word_sender.sv
core/inst_fetch.sv
core/execute_stage.sv
rtl/uart_cpu_top.sv
tb/uart_cpu_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = uart_cpu_tb
FILELIST = uart_cpu_top.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) > $(LOG)
	cat $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
